/* hw/barrier_table.sv */
/*
 * Local barrier table
 * per-barrier arrival counters and waiting masks,
 * releases all waiters on the last arrival
 */
`timescale 1ns/1ps
`default_nettype none

`include "sched_defines.svh"

module barrier_table
    import warp_issue_pkg::*;
(
    input  wire                              clk,
    input  wire                              reset,
    input  ctl_update_t                      upd,
    output logic [`SCHED_NUM_WARPS-1:0]      release_mask,
    output logic                             arrive_wait
);

    logic [`SCHED_NUM_BARRIERS-1:0][`SCHED_WID_BITS-1:0]  arrive_cnt;
    logic [`SCHED_NUM_BARRIERS-1:0][`SCHED_NUM_WARPS-1:0] wait_mask;
    logic [`SCHED_NUM_WARPS-1:0]                          arriver;
    logic                                                 last_arrival;

    assign arriver = `SCHED_NUM_WARPS'(1) << upd.wid;

    // count is encoded as warps minus one
    assign last_arrival = upd.bar_valid && (arrive_cnt[upd.bar_id] == upd.bar_count);

    // waiters and the arriving warp leave together
    assign release_mask = last_arrival ? (wait_mask[upd.bar_id] | arriver) : '0;
    assign arrive_wait  = upd.bar_valid && !last_arrival;

    always_ff @(posedge clk) begin
        if (reset) begin
            arrive_cnt <= '0;
            wait_mask  <= '0;
        end else if (upd.bar_valid) begin
            if (last_arrival) begin
                arrive_cnt[upd.bar_id] <= '0;
                wait_mask[upd.bar_id]  <= '0;
            end else begin
                arrive_cnt[upd.bar_id] <= arrive_cnt[upd.bar_id] + `SCHED_WID_BITS'(1);
                wait_mask[upd.bar_id]  <= wait_mask[upd.bar_id] | arriver;
            end
        end
    end

    // counter tracks the parked warps, so it never passes the warp count
    for (genvar i = 0; i < `SCHED_NUM_BARRIERS; i++) begin : g_cnt_check
        a_cnt_matches_waiters : assert property (
            @(posedge clk) disable iff (reset)
            $countones(wait_mask[i]) == int'(arrive_cnt[i])
        ) else $error("barrier %0d counter out of step with waiting mask", i);
    end

endmodule

`default_nettype wire

/* hw/warp_ctl_decode.sv */
/*
 * Warp control decoder
 * turns one warp-control command into per-effect update strobes
 */
`timescale 1ns/1ps
`default_nettype none

module warp_ctl_decode
    import warp_ctl_pkg::*;
    import warp_issue_pkg::*;
(
    input  warp_ctl_t    ctl,
    output ctl_update_t  upd
);

    logic tmc_hit;
    logic spawn_hit;
    logic bar_hit;

    // opcode to one-hot effect
    always_comb begin
        tmc_hit   = 1'b0;
        spawn_hit = 1'b0;
        bar_hit   = 1'b0;
        unique case (ctl.op)
            CTL_TMC: begin
                tmc_hit = 1'b1;
            end
            CTL_WSPAWN: begin
                spawn_hit = 1'b1;
            end
            CTL_BAR: begin
                bar_hit = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // strobes qualified by valid
    assign upd.tmc_valid   = ctl.valid && tmc_hit;
    assign upd.spawn_valid = ctl.valid && spawn_hit;
    assign upd.bar_valid   = ctl.valid && bar_hit;

    // operands pass unchanged
    assign upd.wid       = ctl.wid;
    assign upd.tmask     = ctl.tmask;
    assign upd.wmask     = ctl.wmask;
    assign upd.spawn_pc  = ctl.spawn_pc;
    assign upd.bar_id    = ctl.bar_id;
    assign upd.bar_count = ctl.bar_count;

    // a valid command always carries an effect, otherwise it is silently dropped
    always_comb begin
        if (ctl.valid) begin
            assert (ctl.op != CTL_NONE)
                else $error("warp control command with op NONE");
        end
    end

endmodule

`default_nettype wire

/* hw/warp_ctl_pkg.sv */
/*
 * Warp control types
 * opcodes and command structs arriving from execute and decode
 */
`default_nettype none

`include "sched_defines.svh"

package warp_ctl_pkg;

    // warp-control command kinds
    typedef enum logic [1:0] {
        CTL_NONE   = 2'd0,
        CTL_TMC    = 2'd1,
        CTL_WSPAWN = 2'd2,
        CTL_BAR    = 2'd3
    } warp_ctl_op_e;

    // one warp-control command
    typedef struct packed {
        logic                            valid;
        warp_ctl_op_e                    op;
        logic [`SCHED_WID_BITS-1:0]      wid;
        logic [`SCHED_NUM_THREADS-1:0]   tmask;
        logic [`SCHED_NUM_WARPS-1:0]     wmask;
        logic [`SCHED_PC_BITS-1:0]       spawn_pc;
        logic [`SCHED_BAR_BITS-1:0]      bar_id;
        // expected warps minus one
        logic [`SCHED_WID_BITS-1:0]      bar_count;
    } warp_ctl_t;

    // resolved branch from the ALU
    typedef struct packed {
        logic                            valid;
        logic [`SCHED_WID_BITS-1:0]      wid;
        logic                            taken;
        logic [`SCHED_PC_BITS-1:0]       dest;
    } branch_t;

    // decode releases a warp
    typedef struct packed {
        logic                            valid;
        logic [`SCHED_WID_BITS-1:0]      wid;
    } unlock_t;

endpackage

`default_nettype wire

/* hw/warp_issue_pkg.sv */
/*
 * Warp issue types
 * scheduled entry and the decoded per-effect update
 */
`default_nettype none

`include "sched_defines.svh"

package warp_issue_pkg;

    // one scheduled warp
    typedef struct packed {
        logic [`SCHED_WID_BITS-1:0]      wid;
        logic [`SCHED_PC_BITS-1:0]       pc;
        logic [`SCHED_NUM_THREADS-1:0]   tmask;
    } issue_entry_t;

    // one-hot effect strobes plus their operands
    typedef struct packed {
        logic                            tmc_valid;
        logic                            spawn_valid;
        logic                            bar_valid;
        logic [`SCHED_WID_BITS-1:0]      wid;
        logic [`SCHED_NUM_THREADS-1:0]   tmask;
        logic [`SCHED_NUM_WARPS-1:0]     wmask;
        logic [`SCHED_PC_BITS-1:0]       spawn_pc;
        logic [`SCHED_BAR_BITS-1:0]      bar_id;
        logic [`SCHED_WID_BITS-1:0]      bar_count;
    } ctl_update_t;

endpackage

`default_nettype wire

/* hw/warp_sched_top.sv */
/*
 * Warp scheduler top
 * control decode, barrier table, warp state and issue select
 */
`timescale 1ns/1ps
`default_nettype none

`include "sched_defines.svh"

module warp_sched_top
    import warp_ctl_pkg::*;
    import warp_issue_pkg::*;
(
    input  wire                          clk,
    input  wire                          reset,
    input  wire [`SCHED_PC_BITS-1:0]     startup_pc,
    input  warp_ctl_t                    ctl,
    input  branch_t                      branch,
    input  unlock_t                      unlock,
    input  wire                          issue_ready,
    output logic                         issue_valid,
    output issue_entry_t                 issue,
    output logic                         busy
);

    ctl_update_t                                           upd;
    logic [`SCHED_NUM_WARPS-1:0]                           release_mask;
    logic                                                  arrive_wait;
    logic [`SCHED_NUM_WARPS-1:0]                           ready_warps;
    logic [`SCHED_NUM_WARPS-1:0][`SCHED_PC_BITS-1:0]      warp_pc;
    logic [`SCHED_NUM_WARPS-1:0][`SCHED_NUM_THREADS-1:0]  warp_tmask;
    logic                                                  take_valid;
    logic [`SCHED_WID_BITS-1:0]                            take_wid;
    logic                                                  fire;
    logic [`SCHED_WID_BITS-1:0]                            fire_wid;

    warp_ctl_decode decode_i (
        .ctl (ctl),
        .upd (upd)
    );

    barrier_table barrier_i (
        .clk          (clk),
        .reset        (reset),
        .upd          (upd),
        .release_mask (release_mask),
        .arrive_wait  (arrive_wait)
    );

    warp_state state_i (
        .clk          (clk),
        .reset        (reset),
        .startup_pc   (startup_pc),
        .upd          (upd),
        .branch       (branch),
        .unlock       (unlock),
        .release_mask (release_mask),
        .arrive_wait  (arrive_wait),
        .take_valid   (take_valid),
        .take_wid     (take_wid),
        .fire         (fire),
        .fire_wid     (fire_wid),
        .ready_warps  (ready_warps),
        .warp_pc      (warp_pc),
        .warp_tmask   (warp_tmask),
        .busy         (busy)
    );

    warp_select select_i (
        .clk         (clk),
        .reset       (reset),
        .ready_warps (ready_warps),
        .warp_pc     (warp_pc),
        .warp_tmask  (warp_tmask),
        .issue_ready (issue_ready),
        .issue_valid (issue_valid),
        .issue       (issue),
        .take_valid  (take_valid),
        .take_wid    (take_wid),
        .fire        (fire),
        .fire_wid    (fire_wid)
    );

endmodule

`default_nettype wire

/* hw/warp_select.sv */
/*
 * Warp select
 * picks the lowest ready warp and holds it in a registered
 * issue entry with valid/ready handshake
 */
`timescale 1ns/1ps
`default_nettype none

`include "sched_defines.svh"

module warp_select
    import warp_issue_pkg::*;
(
    input  wire                                                  clk,
    input  wire                                                  reset,
    input  wire [`SCHED_NUM_WARPS-1:0]                           ready_warps,
    input  wire [`SCHED_NUM_WARPS-1:0][`SCHED_PC_BITS-1:0]      warp_pc,
    input  wire [`SCHED_NUM_WARPS-1:0][`SCHED_NUM_THREADS-1:0]  warp_tmask,
    input  wire                                                  issue_ready,
    output logic                                                 issue_valid,
    output issue_entry_t                                         issue,
    output logic                                                 take_valid,
    output logic [`SCHED_WID_BITS-1:0]                           take_wid,
    output logic                                                 fire,
    output logic [`SCHED_WID_BITS-1:0]                           fire_wid
);

    logic                         sel_valid;
    logic [`SCHED_WID_BITS-1:0]   sel_wid;

    // lowest index wins
    always_comb begin
        sel_valid = 1'b0;
        sel_wid   = '0;
        for (int i = `SCHED_NUM_WARPS - 1; i >= 0; i--) begin
            if (ready_warps[i]) begin
                sel_valid = 1'b1;
                sel_wid   = `SCHED_WID_BITS'(i);
            end
        end
    end

    assign fire     = issue_valid && issue_ready;
    assign fire_wid = issue.wid;

    // load only into an empty or draining entry
    assign take_valid = sel_valid && (!issue_valid || issue_ready);
    assign take_wid   = sel_wid;

    always_ff @(posedge clk) begin
        if (reset) begin
            issue_valid <= 1'b0;
        end else if (take_valid) begin
            issue_valid <= 1'b1;
        end else if (fire) begin
            issue_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take_valid) begin
            issue.wid   <= sel_wid;
            issue.pc    <= warp_pc[sel_wid];
            issue.tmask <= warp_tmask[sel_wid];
        end
    end

    // warp waiting in the entry stays out of selection until accepted
    a_entry_warp_stalled : assert property (
        @(posedge clk) disable iff (reset)
        issue_valid |-> !ready_warps[issue.wid]
    ) else $error("warp %0d ready again before its entry was accepted", issue.wid);

endmodule

`default_nettype wire

/* hw/warp_state.sv */
/*
 * Warp state registers
 * active, stalled, thread mask and PC per warp; applies unlock,
 * spawn, TMC, barrier release, branch, issue stall and PC advance
 */
`timescale 1ns/1ps
`default_nettype none

`include "sched_defines.svh"

module warp_state
    import warp_ctl_pkg::*;
    import warp_issue_pkg::*;
(
    input  wire                                                   clk,
    input  wire                                                   reset,
    input  wire [`SCHED_PC_BITS-1:0]                              startup_pc,
    input  ctl_update_t                                           upd,
    input  branch_t                                               branch,
    input  unlock_t                                               unlock,
    input  wire [`SCHED_NUM_WARPS-1:0]                            release_mask,
    input  wire                                                   arrive_wait,
    input  wire                                                   take_valid,
    input  wire [`SCHED_WID_BITS-1:0]                             take_wid,
    input  wire                                                   fire,
    input  wire [`SCHED_WID_BITS-1:0]                             fire_wid,
    output logic [`SCHED_NUM_WARPS-1:0]                           ready_warps,
    output logic [`SCHED_NUM_WARPS-1:0][`SCHED_PC_BITS-1:0]      warp_pc,
    output logic [`SCHED_NUM_WARPS-1:0][`SCHED_NUM_THREADS-1:0]  warp_tmask,
    output logic                                                  busy
);

    logic [`SCHED_NUM_WARPS-1:0]                          active_warps, active_n;
    logic [`SCHED_NUM_WARPS-1:0]                          stalled_warps, stalled_n;
    logic [`SCHED_NUM_WARPS-1:0][`SCHED_PC_BITS-1:0]     pc_n;
    logic [`SCHED_NUM_WARPS-1:0][`SCHED_NUM_THREADS-1:0] tmask_n;

    // spawn waits here until a single warp remains
    logic                          spawn_pending;
    logic [`SCHED_NUM_WARPS-1:0]   spawn_wmask;
    logic [`SCHED_PC_BITS-1:0]     spawn_pc;
    logic [`SCHED_WID_BITS-1:0]    spawn_wid;
    logic                          spawn_apply;

    assign spawn_apply = spawn_pending && ($countones(active_warps) == 1);

    always_comb begin
        active_n  = active_warps;
        stalled_n = stalled_warps;
        tmask_n   = warp_tmask;
        pc_n      = warp_pc;

        if (unlock.valid) begin
            stalled_n[unlock.wid] = 1'b0;
        end

        if (spawn_apply) begin
            active_n = active_n | spawn_wmask;
            for (int i = 0; i < `SCHED_NUM_WARPS; i++) begin
                if (spawn_wmask[i]) begin
                    tmask_n[i][0] = 1'b1;
                    pc_n[i]       = spawn_pc;
                end
            end
            stalled_n[spawn_wid] = 1'b0;
        end

        // zero mask retires the warp
        if (upd.tmc_valid) begin
            active_n[upd.wid]  = |upd.tmask;
            tmask_n[upd.wid]   = upd.tmask;
            stalled_n[upd.wid] = 1'b0;
        end

        stalled_n = stalled_n & ~release_mask;
        if (arrive_wait) begin
            stalled_n[upd.wid] = 1'b1;
        end

        if (branch.valid) begin
            if (branch.taken) begin
                pc_n[branch.wid] = branch.dest;
            end
            stalled_n[branch.wid] = 1'b0;
        end

        // held until decode lets it go
        if (take_valid) begin
            stalled_n[take_wid] = 1'b1;
        end

        if (fire) begin
            pc_n[fire_wid] = warp_pc[fire_wid] + `SCHED_PC_BITS'(`SCHED_PC_STEP);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active_warps  <= `SCHED_NUM_WARPS'(1);
            stalled_warps <= '0;
            warp_tmask    <= '0;
            warp_tmask[0] <= `SCHED_NUM_THREADS'(1);
            warp_pc       <= '0;
            warp_pc[0]    <= startup_pc;
            spawn_pending <= 1'b0;
            busy          <= 1'b1;
        end else begin
            active_warps  <= active_n;
            stalled_warps <= stalled_n;
            warp_tmask    <= tmask_n;
            warp_pc       <= pc_n;
            busy          <= |active_warps;
            if (spawn_apply) begin
                spawn_pending <= 1'b0;
            end
            if (upd.spawn_valid) begin
                spawn_pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (upd.spawn_valid) begin
            spawn_wmask <= upd.wmask;
            spawn_pc    <= upd.spawn_pc;
            spawn_wid   <= upd.wid;
        end
    end

    assign ready_warps = active_warps & ~stalled_warps;

    // selector may only load a warp this block considers ready
    a_take_active : assert property (
        @(posedge clk) disable iff (reset)
        take_valid |-> (active_warps[take_wid] && !stalled_warps[take_wid])
    ) else $error("warp %0d taken while inactive or stalled", take_wid);

endmodule

`default_nettype wire

/* include/sched_defines.svh */
/*
 * Warp scheduler sizing
 * warp, thread, barrier and PC dimensions shared by packages and RTL
 */
`ifndef SCHED_DEFINES_SVH
`define SCHED_DEFINES_SVH

// core shape
`define SCHED_NUM_WARPS     4
`define SCHED_NUM_THREADS   4
`define SCHED_PC_BITS       32

// local barrier slots
`define SCHED_NUM_BARRIERS  4

// bytes per instruction
`define SCHED_PC_STEP       4

// derived index widths
`define SCHED_WID_BITS      $clog2(`SCHED_NUM_WARPS)
`define SCHED_BAR_BITS      $clog2(`SCHED_NUM_BARRIERS)

`endif

/* run_sim.sh */
#!/bin/sh
# build and run the warp scheduler testbench with Verilator

verilator --binary --timing --assert -f vlog.f --top-module tb_warp_sched \
    -o sim_tb > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 || { cat sim.log; echo "simulator exited abnormally"; exit 1; }
cat sim.log

grep -q "Done: errors found" sim.log && { echo "simulation reported errors"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

/* verif/sched_checker.sv */
/*
 * Scheduler checker
 * compares accepted issue entries with the trace and watches the handshake
 */
`timescale 1ns/1ps
`default_nettype none

`include "sched_defines.svh"

module sched_checker
    import warp_issue_pkg::*;
#(
    parameter int DEPTH = 32
) (
    input  wire           clk,
    input  wire           reset,
    input  wire           issue_valid,
    input  wire           issue_ready,
    input  issue_entry_t  issue,
    input  wire           busy,
    input  logic [63:0]   trace_mem [DEPTH],
    input  wire           end_of_test,
    output int            accept_count,
    output int            error_count
);

    int            value_errors;
    int            protocol_errors;
    int            missing_errors;
    int            exp_ptr;
    logic          hold_valid;
    issue_entry_t  held;

    assign error_count = value_errors + protocol_errors + missing_errors;

    // next expect line at or after start
    // returns -1 once the trace has none left
    function automatic int next_expect(input int start);
        int found;
        found = -1;
        for (int i = start; i < DEPTH; i++) begin
            if (found < 0 && trace_mem[i][63:60] == 4'h4) begin
                found = i;
            end
        end
        return found;
    endfunction

    initial begin
        value_errors    = 0;
        protocol_errors = 0;
        missing_errors  = 0;
        accept_count    = 0;
        exp_ptr         = 0;
        hold_valid      = 1'b0;
    end

    always @(posedge clk) begin
        int idx;
        int bad_values;
        int bad_protocol;
        bad_values   = 0;
        bad_protocol = 0;
        if (!reset) begin
            if (hold_valid && !issue_valid) begin
                $display("issue_valid dropped at %0t before the entry was accepted", $time);
                bad_protocol = bad_protocol + 1;
            end else if (hold_valid && issue != held) begin
                $display("FAIL t=%0t issue expected %h got %h", $time, held, issue);
                bad_protocol = bad_protocol + 1;
            end
            if (issue_valid && !busy) begin
                $display("issue valid at %0t while busy is low", $time);
                bad_protocol = bad_protocol + 1;
            end
            hold_valid <= issue_valid && !issue_ready;
            held       <= issue;

            if (issue_valid && issue_ready) begin
                idx = next_expect(exp_ptr);
                if (idx < 0) begin
                    $display("unexpected issue from warp %0d at %0t", issue.wid, $time);
                    bad_values = bad_values + 1;
                end else begin
                    if (issue.wid != trace_mem[idx][53:52]) begin
                        $display("FAIL t=%0t issue.wid expected %0d got %0d",
                                 $time, trace_mem[idx][53:52], issue.wid);
                        bad_values = bad_values + 1;
                    end
                    if (issue.pc != trace_mem[idx][31:0]) begin
                        $display("FAIL t=%0t issue.pc expected %h got %h",
                                 $time, trace_mem[idx][31:0], issue.pc);
                        bad_values = bad_values + 1;
                    end
                    if (issue.tmask != trace_mem[idx][51:48]) begin
                        $display("FAIL t=%0t issue.tmask expected %b got %b",
                                 $time, trace_mem[idx][51:48], issue.tmask);
                        bad_values = bad_values + 1;
                    end
                    exp_ptr <= idx + 1;
                end
                accept_count <= accept_count + 1;
            end
            value_errors    <= value_errors + bad_values;
            protocol_errors <= protocol_errors + bad_protocol;
        end else begin
            hold_valid <= 1'b0;
        end
    end

    // expected entries never seen count as missing
    always @(posedge end_of_test) begin
        int idx;
        int missing;
        missing = 0;
        idx = next_expect(exp_ptr);
        while (idx >= 0) begin
            $display("expected issue of warp %0d at pc %h never appeared",
                     trace_mem[idx][53:52], trace_mem[idx][31:0]);
            missing = missing + 1;
            idx = next_expect(idx + 1);
        end
        missing_errors = missing;
        $display("errors: value %0d, protocol %0d, missing %0d, total %0d",
                 value_errors, protocol_errors, missing,
                 value_errors + protocol_errors + missing);
    end

endmodule

`default_nettype wire

/* verif/sched_trace.txt */
// kind op wid tmask wmask bar_id bar_count spare pc (hex nibbles, pc 8 digits)
// kind 1 ctl, 2 branch (op=taken), 3 unlock, 4 expect issue, 5 wait idle, f end
4_0_0_1_0_0_0_0_00001000
3_0_0_0_0_0_0_0_00000000
4_0_0_1_0_0_0_0_00001004
3_0_0_0_0_0_0_0_00000000
4_0_0_1_0_0_0_0_00001008
2_1_0_0_0_0_0_0_00002000
4_0_0_1_0_0_0_0_00002000
2_0_0_0_0_0_0_0_00000000
4_0_0_1_0_0_0_0_00002004
1_2_0_0_6_0_0_0_00003000
4_0_0_1_0_0_0_0_00002008
4_0_1_1_0_0_0_0_00003000
4_0_2_1_0_0_0_0_00003000
1_1_1_3_0_0_0_0_00000000
4_0_1_3_0_0_0_0_00003004
1_1_2_0_0_0_0_0_00000000
1_3_0_0_0_1_1_0_00000000
1_3_1_0_0_1_1_0_00000000
4_0_0_1_0_0_0_0_0000200c
4_0_1_3_0_0_0_0_00003008
1_1_0_0_0_0_0_0_00000000
1_1_1_0_0_0_0_0_00000000
5_0_0_0_0_0_0_0_00000000
f_0_0_0_0_0_0_0_00000000

/* verif/tb_warp_sched.sv */
/*
 * Warp scheduler testbench
 * plays the command trace into the DUT under random issue back-pressure
 */
`timescale 1ns/1ps
`default_nettype none

`include "sched_defines.svh"

module tb_warp_sched
    import warp_ctl_pkg::*;
    import warp_issue_pkg::*;
;

    localparam int DEPTH = 32;

    logic                        clk;
    logic                        reset;
    logic [`SCHED_PC_BITS-1:0]   startup_pc;
    warp_ctl_t                   ctl;
    branch_t                     branch;
    unlock_t                     unlock;
    logic                        issue_ready;
    logic                        issue_valid;
    issue_entry_t                issue;
    logic                        busy;

    logic [63:0]  trace_mem [DEPTH];
    logic         end_of_test;
    int           accept_count;
    int           error_count;
    int           cycle_count;
    int           timeout_limit;
    int           exp_seen;
    integer       seed;

    warp_sched_top dut_i (
        .clk         (clk),
        .reset       (reset),
        .startup_pc  (startup_pc),
        .ctl         (ctl),
        .branch      (branch),
        .unlock      (unlock),
        .issue_ready (issue_ready),
        .issue_valid (issue_valid),
        .issue       (issue),
        .busy        (busy)
    );

    sched_checker #(.DEPTH(DEPTH)) checker_i (
        .clk          (clk),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .issue        (issue),
        .busy         (busy),
        .trace_mem    (trace_mem),
        .end_of_test  (end_of_test),
        .accept_count (accept_count),
        .error_count  (error_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ready low about one cycle in four
    always @(posedge clk) begin
        issue_ready <= (($random(seed) & 3) != 0);
        cycle_count <= cycle_count + 1;
    end

    // one-cycle strobe from a trace line
    task automatic play_line(input logic [63:0] line);
        @(posedge clk);
        case (line[63:60])
            4'h1: begin
                ctl.valid     <= 1'b1;
                ctl.op        <= warp_ctl_op_e'(line[57:56]);
                ctl.wid       <= line[53:52];
                ctl.tmask     <= line[51:48];
                ctl.wmask     <= line[47:44];
                ctl.bar_id    <= line[41:40];
                ctl.bar_count <= line[37:36];
                ctl.spawn_pc  <= line[31:0];
            end
            4'h2: begin
                branch.valid <= 1'b1;
                branch.taken <= line[56];
                branch.wid   <= line[53:52];
                branch.dest  <= line[31:0];
            end
            default: begin
                unlock.valid <= 1'b1;
                unlock.wid   <= line[53:52];
            end
        endcase
        @(posedge clk);
        ctl.valid    <= 1'b0;
        branch.valid <= 1'b0;
        unlock.valid <= 1'b0;
    endtask

    initial begin
        int lines;
        seed          = 32'hb21810f7;
        reset         = 1'b1;
        startup_pc    = 32'h0000_1000;
        ctl           = '0;
        branch        = '0;
        unlock        = '0;
        issue_ready   = 1'b0;
        end_of_test   = 1'b0;
        cycle_count   = 0;
        exp_seen      = 0;
        // end markers tagged with their own index
        for (int i = 0; i < DEPTH; i++) begin
            trace_mem[i] = {4'hf, 28'h0, 32'(i)};
        end
        $readmemh("verif/sched_trace.txt", trace_mem);
        lines = 0;
        while (lines < DEPTH && trace_mem[lines][63:60] != 4'hf) begin
            lines = lines + 1;
        end
        timeout_limit = (lines + 1) * 60;

        repeat (5) @(posedge clk);
        reset <= 1'b0;

        for (int i = 0; i < lines; i++) begin
            if (trace_mem[i][63:60] == 4'h4) begin
                exp_seen = exp_seen + 1;
                @(posedge clk);
                while (accept_count < exp_seen) @(posedge clk);
            end else if (trace_mem[i][63:60] == 4'h5) begin
                @(posedge clk);
                while (busy) @(posedge clk);
            end else begin
                play_line(trace_mem[i]);
            end
        end

        repeat (6) @(posedge clk);
        end_of_test = 1'b1;
        #1;
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // watchdog sized from the trace length
    initial begin
        @(posedge clk);
        while (cycle_count < timeout_limit) @(posedge clk);
        $display("timeout after %0d cycles, the DUT stopped issuing expected entries",
                 cycle_count);
        end_of_test = 1'b1;
        #1;
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+include
hw/warp_ctl_pkg.sv
hw/warp_issue_pkg.sv
hw/warp_ctl_decode.sv
hw/barrier_table.sv
hw/warp_state.sv
hw/warp_select.sv
hw/warp_sched_top.sv
verif/sched_checker.sv
verif/tb_warp_sched.sv
